/* hw/sobelPkg.sv */
package sobelPkg;

    // Pixel and line geometry
    localparam int unsigned pixelWidth = 8;
    localparam int unsigned lineWidth = 16;
    localparam int unsigned columnWidth = 4;

    // Arithmetic widths, gradients reach +/-1020 and the magnitude 2040
    localparam int unsigned gradientWidth = 11;
    localparam int unsigned magnitudeWidth = 11;

    // Register widths
    localparam int unsigned thresholdWidth = 16;
    localparam int unsigned edgeCountWidth = 16;

    // Custom instruction number of this unit
    localparam logic [7:0] customId = 8'd12;

    typedef logic [pixelWidth-1:0] pixelT;
    typedef logic signed [gradientWidth-1:0] gradientT;

    // Taken from ciValueA[12:9]
    // Any other code is a no-op that returns zero
    typedef enum logic [3:0] {
        ciReadThreshold  = 4'b1000,
        ciWriteThreshold = 4'b1001,
        ciReadEdgeCount  = 4'b1010
    } ciOpcode;

    // Lines started since the last vsync
    typedef enum logic [1:0] {
        rowNone   = 2'd0,
        rowFirst  = 2'd1,
        rowSecond = 2'd2,
        rowFull   = 2'd3
    } rowState;

endpackage

/* hw/windowIf.sv */
`timescale 1ns/1ps

interface windowIf;

    // Rows top to bottom, columns left to right
    sobelPkg::pixelT topLeft, topCentre, topRight;
    sobelPkg::pixelT middleLeft, middleCentre, middleRight;
    sobelPkg::pixelT bottomLeft, bottomCentre, bottomRight;
    logic windowValid;

    modport producer (
        output topLeft, topCentre, topRight,
        output middleLeft, middleCentre, middleRight,
        output bottomLeft, bottomCentre, bottomRight,
        output windowValid
    );

    modport consumer (
        input topLeft, topCentre, topRight,
        input middleLeft, middleCentre, middleRight,
        input bottomLeft, bottomCentre, bottomRight,
        input windowValid
    );

endinterface

/* hw/controlRegisters.sv */
`timescale 1ns/1ps

module controlRegisters (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                vsync,
    input  logic                                ciStart,
    input  logic [7:0]                          ciN,
    input  logic [31:0]                         ciValueA,
    input  logic [31:0]                         ciValueB,
    input  logic                                edgeValid,
    input  logic                                edgeFlag,
    output logic [31:0]                         ciResult,
    output logic                                ciDone,
    output logic [sobelPkg::thresholdWidth-1:0] threshold
);

    logic validInstr;
    sobelPkg::ciOpcode opcode;
    logic [sobelPkg::edgeCountWidth-1:0] edgeCount;
    logic countFull;

    assign validInstr = ciStart && (ciN == sobelPkg::customId);
    assign opcode = sobelPkg::ciOpcode'(ciValueA[12:9]);

    // Completes in the same cycle
    assign ciDone = validInstr;

    always_comb begin
        ciResult = 32'd0;
        if (validInstr) begin
            case (opcode)
                sobelPkg::ciReadThreshold: begin
                    ciResult = 32'(threshold);
                end
                sobelPkg::ciReadEdgeCount: begin
                    ciResult = 32'(edgeCount);
                end
                default: begin
                    ciResult = 32'd0;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            threshold <= '0;
        end else if (validInstr && opcode == sobelPkg::ciWriteThreshold) begin
            threshold <= ciValueB[sobelPkg::thresholdWidth-1:0];
        end
    end

    assign countFull = (edgeCount == {sobelPkg::edgeCountWidth{1'b1}});

    // Edge pixels in the current frame, saturating
    always_ff @(posedge clock) begin
        if (reset || vsync) begin
            edgeCount <= '0;
        end else if (edgeValid && edgeFlag && !countFull) begin
            edgeCount <= edgeCount + 1'b1;
        end
    end

endmodule

/* hw/windowBuffer.sv */
`timescale 1ns/1ps

module windowBuffer (
    input  logic            clock,
    input  logic            reset,
    input  logic            hsync,
    input  logic            vsync,
    input  logic            validCamera,
    input  sobelPkg::pixelT camData,
    windowIf.producer       window
);

    // lineOlder holds row r-2, lineNewer holds row r-1
    sobelPkg::pixelT lineOlder [sobelPkg::lineWidth];
    sobelPkg::pixelT lineNewer [sobelPkg::lineWidth];

    logic [sobelPkg::columnWidth-1:0] column;
    sobelPkg::rowState rowCurrent;
    sobelPkg::rowState rowNext;

    sobelPkg::pixelT olderPixel;
    sobelPkg::pixelT newerPixel;
    logic windowComplete;

    assign olderPixel = lineOlder[column];
    assign newerPixel = lineNewer[column];

    assign windowComplete = validCamera
                            && (column >= sobelPkg::columnWidth'(2))
                            && (rowCurrent == sobelPkg::rowFull);

    always_comb begin
        rowNext = rowCurrent;
        if (vsync) begin
            rowNext = sobelPkg::rowNone;
        end else if (hsync) begin
            case (rowCurrent)
                sobelPkg::rowNone: begin
                    rowNext = sobelPkg::rowFirst;
                end
                sobelPkg::rowFirst: begin
                    rowNext = sobelPkg::rowSecond;
                end
                default: begin
                    rowNext = sobelPkg::rowFull;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rowCurrent <= sobelPkg::rowNone;
        end else begin
            rowCurrent <= rowNext;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || hsync) begin
            column <= '0;
        end else if (validCamera) begin
            column <= column + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            window.windowValid <= 1'b0;
        end else begin
            window.windowValid <= windowComplete;
        end
    end

    // Line memories move down one row at this column
    always_ff @(posedge clock) begin
        if (validCamera) begin
            lineOlder[column] <= newerPixel;
            lineNewer[column] <= camData;
        end
    end

    // Shift the new three-row column in from the right
    always_ff @(posedge clock) begin
        if (validCamera) begin
            window.topLeft      <= window.topCentre;
            window.topCentre    <= window.topRight;
            window.topRight     <= olderPixel;
            window.middleLeft   <= window.middleCentre;
            window.middleCentre <= window.middleRight;
            window.middleRight  <= newerPixel;
            window.bottomLeft   <= window.bottomCentre;
            window.bottomCentre <= window.bottomRight;
            window.bottomRight  <= camData;
        end
    end

endmodule

/* hw/gradientX.sv */
`timescale 1ns/1ps

module gradientX (
    input  logic               clock,
    input  logic               reset,
    windowIf.consumer          window,
    output sobelPkg::gradientT gradX,
    output logic               gradXValid
);

    sobelPkg::gradientT rightSum;
    sobelPkg::gradientT leftSum;

    // Weights 1, 2, 1 from top to bottom
    assign rightSum = sobelPkg::gradientT'(window.topRight)
                      + (sobelPkg::gradientT'(window.middleRight) <<< 1)
                      + sobelPkg::gradientT'(window.bottomRight);

    assign leftSum = sobelPkg::gradientT'(window.topLeft)
                     + (sobelPkg::gradientT'(window.middleLeft) <<< 1)
                     + sobelPkg::gradientT'(window.bottomLeft);

    always_ff @(posedge clock) begin
        if (window.windowValid) begin
            gradX <= rightSum - leftSum;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            gradXValid <= 1'b0;
        end else begin
            gradXValid <= window.windowValid;
        end
    end

endmodule

/* hw/gradientY.sv */
`timescale 1ns/1ps

module gradientY (
    input  logic               clock,
    input  logic               reset,
    windowIf.consumer          window,
    output sobelPkg::gradientT gradY,
    output logic               gradYValid
);

    sobelPkg::gradientT bottomSum;
    sobelPkg::gradientT topSum;

    // Weights 1, 2, 1 from left to right
    assign bottomSum = sobelPkg::gradientT'(window.bottomLeft)
                       + (sobelPkg::gradientT'(window.bottomCentre) <<< 1)
                       + sobelPkg::gradientT'(window.bottomRight);

    assign topSum = sobelPkg::gradientT'(window.topLeft)
                    + (sobelPkg::gradientT'(window.topCentre) <<< 1)
                    + sobelPkg::gradientT'(window.topRight);

    always_ff @(posedge clock) begin
        if (window.windowValid) begin
            gradY <= bottomSum - topSum;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            gradYValid <= 1'b0;
        end else begin
            gradYValid <= window.windowValid;
        end
    end

endmodule

/* hw/edgeDecision.sv */
`timescale 1ns/1ps

module edgeDecision (
    input  logic                                clock,
    input  logic                                reset,
    input  sobelPkg::gradientT                  gradX,
    input  sobelPkg::gradientT                  gradY,
    input  logic                                gradXValid,
    input  logic [sobelPkg::thresholdWidth-1:0] threshold,
    output logic [sobelPkg::magnitudeWidth-1:0] edgeMagnitude,
    output logic                                edgeFlag,
    output logic                                edgeValid
);

    logic [sobelPkg::magnitudeWidth-1:0] absX;
    logic [sobelPkg::magnitudeWidth-1:0] absY;
    logic [sobelPkg::magnitudeWidth-1:0] magnitudeNext;
    logic aboveThreshold;

    // No overflow here, each absolute value stays at or below 1020
    assign absX = gradX[sobelPkg::gradientWidth-1] ? sobelPkg::magnitudeWidth'(-gradX)
                                                   : sobelPkg::magnitudeWidth'(gradX);
    assign absY = gradY[sobelPkg::gradientWidth-1] ? sobelPkg::magnitudeWidth'(-gradY)
                                                   : sobelPkg::magnitudeWidth'(gradY);

    assign magnitudeNext = absX + absY;
    assign aboveThreshold = sobelPkg::thresholdWidth'(magnitudeNext) > threshold;

    always_ff @(posedge clock) begin
        if (reset) begin
            edgeMagnitude <= '0;
            edgeFlag <= 1'b0;
        end else if (gradXValid) begin
            edgeMagnitude <= magnitudeNext;
            edgeFlag <= aboveThreshold;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            edgeValid <= 1'b0;
        end else begin
            edgeValid <= gradXValid;
        end
    end

endmodule

/* hw/sobelAccelerator.sv */
`timescale 1ns/1ps

module sobelAccelerator (
    input  logic        clock,
    input  logic        reset,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        validCamera,
    input  logic        ciStart,
    input  logic [7:0]  camData,
    input  logic [7:0]  ciN,
    input  logic [31:0] ciValueA,
    input  logic [31:0] ciValueB,
    output logic [31:0] ciResult,
    output logic        ciDone,
    output logic        edgeValid,
    output logic        edgeFlag,
    output logic [10:0] edgeMagnitude
);

    windowIf windowBus ();

    sobelPkg::gradientT gradX;
    sobelPkg::gradientT gradY;
    logic gradXValid;
    logic [sobelPkg::thresholdWidth-1:0] threshold;

    windowBuffer i_windowBuffer (
        .clock       (clock),
        .reset       (reset),
        .hsync       (hsync),
        .vsync       (vsync),
        .validCamera (validCamera),
        .camData     (camData),
        .window      (windowBus.producer)
    );

    gradientX i_gradientX (
        .clock      (clock),
        .reset      (reset),
        .window     (windowBus.consumer),
        .gradX      (gradX),
        .gradXValid (gradXValid)
    );

    // Strobe matches gradXValid, so it stays open
    gradientY i_gradientY (
        .clock      (clock),
        .reset      (reset),
        .window     (windowBus.consumer),
        .gradY      (gradY),
        .gradYValid ()
    );

    edgeDecision i_edgeDecision (
        .clock         (clock),
        .reset         (reset),
        .gradX         (gradX),
        .gradY         (gradY),
        .gradXValid    (gradXValid),
        .threshold     (threshold),
        .edgeMagnitude (edgeMagnitude),
        .edgeFlag      (edgeFlag),
        .edgeValid     (edgeValid)
    );

    controlRegisters i_controlRegisters (
        .clock     (clock),
        .reset     (reset),
        .vsync     (vsync),
        .ciStart   (ciStart),
        .ciN       (ciN),
        .ciValueA  (ciValueA),
        .ciValueB  (ciValueB),
        .edgeValid (edgeValid),
        .edgeFlag  (edgeFlag),
        .ciResult  (ciResult),
        .ciDone    (ciDone),
        .threshold (threshold)
    );

endmodule

/* test/sobelTb.sv */
`timescale 1ns/1ps

module sobelTb;

    localparam int halfPeriod = 10;
    localparam int driveDelay = 2;
    localparam int resetCycles = 3;
    localparam int timeoutCycles = 300;
    localparam int linesPerFrame = 4;
    localparam int pixelsPerLine = sobelPkg::lineWidth;
    localparam int windowsPerFrame = 28;
    localparam int pipelineLatency = 3;

    // Word offsets in the vector file
    localparam int thresholdBase = 0;
    localparam int pixelBase = 2;
    localparam int magnitudeBase = 66;
    localparam int flagBaseA = 94;
    localparam int flagBaseB = 122;
    localparam int countBase = 150;
    localparam int vectorWords = 152;

    logic clock;
    logic reset;
    logic hsync;
    logic vsync;
    logic validCamera;
    logic ciStart;
    logic [7:0] camData;
    logic [7:0] ciN;
    logic [31:0] ciValueA;
    logic [31:0] ciValueB;
    logic [31:0] ciResult;
    logic ciDone;
    logic edgeValid;
    logic edgeFlag;
    logic [10:0] edgeMagnitude;

    logic [15:0] vectors [vectorWords];
    int unsigned cycleCount = 0;
    int unsigned presentedCycles [$];
    int resultTotal;

    sobelAccelerator i_sobelAccelerator (
        .clock         (clock),
        .reset         (reset),
        .hsync         (hsync),
        .vsync         (vsync),
        .validCamera   (validCamera),
        .ciStart       (ciStart),
        .camData       (camData),
        .ciN           (ciN),
        .ciValueA      (ciValueA),
        .ciValueB      (ciValueB),
        .ciResult      (ciResult),
        .ciDone        (ciDone),
        .edgeValid     (edgeValid),
        .edgeFlag      (edgeFlag),
        .edgeMagnitude (edgeMagnitude)
    );

    always #halfPeriod clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    // Every strobe of the whole run including strays
    always @(negedge clock) begin
        if (edgeValid === 1'b1) begin
            resultTotal++;
        end
    end

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected) else begin
            stopRun($sformatf("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                              $time, name, expected, actual));
        end
    endtask

    task automatic nextDriveSlot();
        @(posedge clock);
        #driveDelay;
    endtask

    task automatic issueInstruction(input logic [7:0] number, input logic [3:0] code,
                                    input logic [31:0] operand, input logic expectDone,
                                    input logic [31:0] expectResult);
        nextDriveSlot();
        ciStart = 1'b1;
        ciN = number;
        ciValueA = {19'd0, code, 9'd0};
        ciValueB = operand;
        @(negedge clock);
        checkValue("ciDone", 32'(ciDone), 32'(expectDone));
        checkValue("ciResult", ciResult, expectResult);
        nextDriveSlot();
        ciStart = 1'b0;
        ciN = 8'd0;
        ciValueA = 32'd0;
        ciValueB = 32'd0;
    endtask

    task automatic pulseVsync();
        nextDriveSlot();
        vsync = 1'b1;
        nextDriveSlot();
        vsync = 1'b0;
    endtask

    // hsync gets a cycle of its own before each line
    task automatic sendFrame(input bit withGaps);
        int gap;
        for (int line = 0; line < linesPerFrame; line++) begin
            nextDriveSlot();
            validCamera = 1'b0;
            hsync = 1'b1;
            for (int column = 0; column < pixelsPerLine; column++) begin
                nextDriveSlot();
                hsync = 1'b0;
                validCamera = 1'b1;
                camData = vectors[pixelBase + line * pixelsPerLine + column][7:0];
                if (line >= 2 && column >= 2) begin
                    presentedCycles.push_back(cycleCount);
                end
                if (withGaps) begin
                    gap = $urandom_range(2, 0);
                    repeat (gap) begin
                        nextDriveSlot();
                        validCamera = 1'b0;
                    end
                end
            end
        end
        nextDriveSlot();
        validCamera = 1'b0;
    endtask

    task automatic waitForEdgeValid();
        int waited;
        waited = 0;
        @(negedge clock);
        while (edgeValid !== 1'b1) begin
            waited++;
            if (waited > timeoutCycles) begin
                stopRun("Timed out waiting for edgeValid");
            end
            @(negedge clock);
        end
    endtask

    task automatic checkFrame(input logic [15:0] thresholdValue, input int flagBase);
        logic [10:0] expectedMagnitude;
        logic expectedFlag;
        int unsigned presented;
        for (int index = 0; index < windowsPerFrame; index++) begin
            waitForEdgeValid();
            expectedMagnitude = vectors[magnitudeBase + index][10:0];
            expectedFlag = vectors[flagBase + index][0];
            checkValue("edgeMagnitude", 32'(edgeMagnitude), 32'(expectedMagnitude));
            checkValue("edgeFlag", 32'(edgeFlag), 32'(expectedFlag));
            // Strictly greater than the threshold
            checkValue("edgeFlag by threshold", 32'(edgeFlag),
                       32'(expectedMagnitude > thresholdValue));
            if (presentedCycles.size() == 0) begin
                stopRun("edgeValid arrived without a completing pixel");
            end else begin
                presented = presentedCycles.pop_front();
                checkValue("edgeValid latency", cycleCount - presented, pipelineLatency);
            end
        end
    endtask

    task automatic runFrame(input logic [15:0] thresholdValue, input int flagBase,
                            input logic [15:0] expectedCount, input bit withGaps);
        issueInstruction(sobelPkg::customId, sobelPkg::ciWriteThreshold,
                         32'(thresholdValue), 1'b1, 32'd0);
        issueInstruction(sobelPkg::customId, sobelPkg::ciReadThreshold,
                         32'd0, 1'b1, 32'(thresholdValue));
        pulseVsync();
        fork
            sendFrame(withGaps);
            checkFrame(thresholdValue, flagBase);
        join
        issueInstruction(sobelPkg::customId, sobelPkg::ciReadEdgeCount,
                         32'd0, 1'b1, 32'(expectedCount));
    endtask

    initial begin
        void'($urandom(67483));
        clock = 1'b0;
        reset = 1'b1;
        hsync = 1'b0;
        vsync = 1'b0;
        validCamera = 1'b0;
        ciStart = 1'b0;
        camData = 8'd0;
        ciN = 8'd0;
        ciValueA = 32'd0;
        ciValueB = 32'd0;
        resultTotal = 0;
        $readmemh("test/sobelVectors.txt", vectors);
        repeat (resetCycles) @(posedge clock);
        #driveDelay;
        reset = 1'b0;
        @(negedge clock);
        checkValue("ciDone", 32'(ciDone), 32'd0);
        checkValue("edgeValid", 32'(edgeValid), 32'd0);
        checkValue("edgeFlag", 32'(edgeFlag), 32'd0);
        checkValue("edgeMagnitude", 32'(edgeMagnitude), 32'd0);
        checkValue("ciResult", ciResult, 32'd0);
        issueInstruction(sobelPkg::customId, sobelPkg::ciReadThreshold, 32'd0, 1'b1, 32'd0);
        issueInstruction(sobelPkg::customId, sobelPkg::ciWriteThreshold,
                         32'(vectors[thresholdBase]), 1'b1, 32'd0);
        // Another unit's number is ignored
        issueInstruction(sobelPkg::customId + 8'd1, sobelPkg::ciWriteThreshold,
                         32'h1234, 1'b0, 32'd0);
        issueInstruction(8'd3, sobelPkg::ciReadThreshold, 32'd0, 1'b0, 32'd0);
        issueInstruction(sobelPkg::customId, sobelPkg::ciReadThreshold,
                         32'd0, 1'b1, 32'(vectors[thresholdBase]));
        issueInstruction(sobelPkg::customId, 4'h0, 32'hFFFF, 1'b1, 32'd0);
        runFrame(vectors[thresholdBase], flagBaseA, vectors[countBase], 1'b0);
        runFrame(vectors[thresholdBase + 1], flagBaseB, vectors[countBase + 1], 1'b1);
        pulseVsync();
        issueInstruction(sobelPkg::customId, sobelPkg::ciReadEdgeCount, 32'd0, 1'b1, 32'd0);
        repeat (10) @(negedge clock);
        if (resultTotal == 2 * windowsPerFrame) begin
            $display("No errors");
            $finish;
        end else begin
            stopRun($sformatf("Expected %0d edge results in total, counted %0d",
                              2 * windowsPerFrame, resultTotal));
        end
    end

endmodule

/* test/sobelVectors.txt */
// Hex words in order: threshold A and B, then 4 lines of 16 pixels, then 28 magnitudes,
// then 28 flags at threshold A, 28 flags at threshold B, and the edge counts at A and B
// Thresholds 500 and 900
1F4 384
// Frame pixels, one camera line per row
00 00 00 64 C8 C8 C8 32 32 00 00 D7 D7 1E 1E 1E
1E 1E 1E 82 E6 E6 E6 50 50 1E 1E F5 F5 3C 3C 3C
28 28 28 8C F0 F0 F0 5A 5A 28 28 FF FF 46 46 46
0A 0A 0A 6E D2 D2 D2 3C 3C 0A 0A E1 E1 28 28 28
// Magnitudes, windows of line 2 then line 3
0A0 230 3C0 230 0A0 2F8 2F8
168 168 3FC 3FC 384 384 0A0
050 1E0 370 1E0 050 2A8 2A8
118 118 3AC 3AC 334 334 050
// Flags at threshold A
0 1 1 1 0 1 1 0 0 1 1 1 1 0
0 0 1 0 0 1 1 0 0 1 1 1 1 0
// Flags at threshold B, equal magnitude is not an edge
0 0 1 0 0 0 0 0 0 1 1 0 0 0
0 0 0 0 0 0 0 0 0 1 1 0 0 0
// Edge counts at A and B
10 5

/* project.f */
hw/sobelPkg.sv
hw/windowIf.sv
hw/controlRegisters.sv
hw/windowBuffer.sv
hw/gradientX.sv
hw/gradientY.sv
hw/edgeDecision.sv
hw/sobelAccelerator.sv
test/sobelTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module sobelTb -o sobelSim \
    && ./obj_dir/sobelSim \
    || { echo "Simulation run failed"; exit 1; }
